// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // Data path widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] inst_t;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operations, operand b is either rs2 or the immediate
  typedef enum logic [1:0] {
    ADD    = 2'd0,
    SUB    = 2'd1,
    PASS_B = 2'd2
  } alu_op_e;

  // First fetch address
  parameter word_t PC_RESET = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // Byte address and data word on the shared memory port
  typedef logic [31:0] mem_addr_t;
  typedef logic [31:0] mem_data_t;

  // Peers competing for the memory port
  typedef enum logic {
    REQ_IFU = 1'b0,
    REQ_EXU = 1'b1
  } requester_e;

endpackage

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      we_i,
  input  wire core_pkg::reg_addr_t waddr_i,
  input  wire core_pkg::word_t     wdata_i,
  input  wire core_pkg::reg_addr_t raddr1_i,
  input  wire core_pkg::reg_addr_t raddr2_i,
  output core_pkg::word_t          rdata1_o,
  output core_pkg::word_t          rdata2_o
);

  core_pkg::word_t regs_q [NUM_REGS];

  // Indices past NUM_REGS read as zero, e.g. in an RV32E build
  assign rdata1_o = (int'(raddr1_i) < NUM_REGS) ? regs_q[raddr1_i] : '0;
  assign rdata2_o = (int'(raddr2_i) < NUM_REGS) ? regs_q[raddr2_i] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0) && (int'(waddr_i) < NUM_REGS)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 stays zero across any sequence of retired writes
  x0_zero_a: assert property (@(posedge clk) disable iff (rst) regs_q[0] == '0);

endmodule

`default_nettype wire

// ==== src/ifu.sv ====
`timescale 1ns/10ps
`default_nettype none

module ifu (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     retire_i,
  input  wire core_pkg::word_t    next_pc_i,
  input  wire                     halt_i,
  input  wire                     ready_i,
  output logic                    valid_o,
  output core_pkg::inst_t         inst_o,
  output core_pkg::word_t         pc_o,
  output logic                    mem_req_o,
  output mem_pkg::mem_addr_t      mem_addr_o,
  input  wire                     mem_ack_i,
  input  wire mem_pkg::mem_data_t mem_rdata_i
);

  typedef enum logic [1:0] {
    FETCH,
    WAIT_ACK,
    HOLD,
    IDLE
  } state_e;

  state_e          state_q;
  core_pkg::word_t pc_q;
  core_pkg::inst_t inst_q;

  assign pc_o       = pc_q;
  assign inst_o     = inst_q;
  assign valid_o    = (state_q == HOLD);
  assign mem_addr_o = pc_q;
  // No request once the core has halted
  assign mem_req_o  = ((state_q == FETCH) && !halt_i) || (state_q == WAIT_ACK);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FETCH;
      pc_q    <= core_pkg::PC_RESET;
    end else begin
      case (state_q)
        FETCH: begin
          state_q <= halt_i ? IDLE : WAIT_ACK;
        end
        WAIT_ACK: begin
          if (mem_ack_i) begin
            state_q <= HOLD;
          end
        end
        HOLD: begin
          if (ready_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          if (retire_i) begin
            pc_q    <= next_pc_i;
            state_q <= FETCH;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == WAIT_ACK) && mem_ack_i) begin
      inst_q <= mem_rdata_i;
    end
  end

  no_req_while_valid_a: assert property (@(posedge clk) disable iff (rst)
    valid_o |-> !mem_req_o);

endmodule

`default_nettype wire

// ==== src/idu.sv ====
`timescale 1ns/10ps
`default_nettype none

module idu (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  valid_i,
  output logic                 ready_o,
  input  wire core_pkg::inst_t inst_i,
  input  wire core_pkg::word_t pc_i,
  output core_pkg::reg_addr_t  rs1_o,
  output core_pkg::reg_addr_t  rs2_o,
  input  wire core_pkg::word_t rdata1_i,
  input  wire core_pkg::word_t rdata2_i,
  output logic                 valid_o,
  input  wire                  ready_i,
  output core_pkg::word_t      op1_o,
  output core_pkg::word_t      op2_o,
  output core_pkg::word_t      imm_o,
  output core_pkg::word_t      pc_o,
  output core_pkg::reg_addr_t  rd_o,
  output logic                 rwen_o,
  output core_pkg::alu_op_e    alu_op_o,
  output core_pkg::opcode_e    opcode_o,
  output logic                 is_bne_o
);

  core_pkg::word_t   imm_i_type;
  core_pkg::word_t   imm_s_type;
  core_pkg::word_t   imm_b_type;
  core_pkg::word_t   imm_u_type;
  core_pkg::word_t   imm_j_type;
  core_pkg::word_t   dec_imm;
  logic              dec_rwen;
  core_pkg::alu_op_e dec_alu_op;
  core_pkg::opcode_e dec_opcode;
  logic              valid_q;
  logic              accept;

  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                       inst_i[30:21], 1'b0};

  // Register file read ports follow the incoming instruction
  assign rs1_o   = inst_i[19:15];
  assign rs2_o   = inst_i[24:20];
  assign ready_o = !valid_q;
  assign valid_o = valid_q;
  assign accept  = valid_i && ready_o;

  always_comb begin
    dec_opcode = core_pkg::opcode_e'(inst_i[6:0]);
    dec_rwen   = 1'b0;
    dec_alu_op = core_pkg::ADD;
    dec_imm    = imm_i_type;
    case (inst_i[6:0])
      core_pkg::OP: begin
        dec_rwen   = 1'b1;
        dec_alu_op = inst_i[30] ? core_pkg::SUB : core_pkg::ADD;
      end
      core_pkg::OP_IMM, core_pkg::LOAD, core_pkg::JALR: begin
        dec_rwen = 1'b1;
      end
      core_pkg::LUI: begin
        dec_rwen   = 1'b1;
        dec_alu_op = core_pkg::PASS_B;
        dec_imm    = imm_u_type;
      end
      core_pkg::STORE:  dec_imm = imm_s_type;
      core_pkg::BRANCH: dec_imm = imm_b_type;
      core_pkg::JAL: begin
        dec_rwen = 1'b1;
        dec_imm  = imm_j_type;
      end
      core_pkg::SYSTEM: ;
      // Unknown opcodes halt like ebreak
      default: dec_opcode = core_pkg::SYSTEM;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op1_o    <= rdata1_i;
      op2_o    <= rdata2_i;
      imm_o    <= dec_imm;
      pc_o     <= pc_i;
      rd_o     <= inst_i[11:7];
      rwen_o   <= dec_rwen;
      alu_op_o <= dec_alu_op;
      opcode_o <= dec_opcode;
      is_bne_o <= inst_i[12];
    end
  end

endmodule

`default_nettype wire

// ==== src/exu.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      valid_i,
  output logic                     ready_o,
  input  wire core_pkg::word_t     op1_i,
  input  wire core_pkg::word_t     op2_i,
  input  wire core_pkg::word_t     imm_i,
  input  wire core_pkg::word_t     pc_i,
  input  wire core_pkg::reg_addr_t rd_i,
  input  wire                      rwen_i,
  input  wire core_pkg::alu_op_e   alu_op_i,
  input  wire core_pkg::opcode_e   opcode_i,
  input  wire                      is_bne_i,
  output logic                     retire_o,
  output core_pkg::word_t          next_pc_o,
  output core_pkg::word_t          wdata_o,
  output core_pkg::reg_addr_t      waddr_o,
  output logic                     wen_o,
  output logic                     halt_o,
  output logic                     mem_req_o,
  output mem_pkg::mem_addr_t       mem_addr_o,
  output logic                     mem_we_o,
  output mem_pkg::mem_data_t       mem_wdata_o,
  input  wire                      mem_ack_i,
  input  wire mem_pkg::mem_data_t  mem_rdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    MEM_REQ,
    MEM_WAIT
  } state_e;

  state_e          state_q;
  logic            halt_q;
  core_pkg::word_t load_q;
  core_pkg::word_t alu_b;
  core_pkg::word_t alu_res;
  core_pkg::word_t pc_plus4;
  core_pkg::word_t pc_target;
  logic            take;
  logic            is_mem;

  // Decode outputs stay put until the next accept, which follows retire
  assign alu_b     = (opcode_i == core_pkg::OP) ? op2_i : imm_i;
  assign pc_plus4  = pc_i + 32'd4;
  assign pc_target = pc_i + imm_i;
  assign take      = is_bne_i ? (op1_i != op2_i) : (op1_i == op2_i);
  assign is_mem    = (opcode_i == core_pkg::LOAD) || (opcode_i == core_pkg::STORE);

  always_comb begin
    case (alu_op_i)
      core_pkg::SUB:    alu_res = op1_i - alu_b;
      core_pkg::PASS_B: alu_res = alu_b;
      default:          alu_res = op1_i + alu_b;
    endcase
  end

  always_comb begin
    case (opcode_i)
      core_pkg::JAL:    next_pc_o = pc_target;
      core_pkg::JALR:   next_pc_o = {alu_res[31:1], 1'b0};
      core_pkg::BRANCH: next_pc_o = take ? pc_target : pc_plus4;
      default:          next_pc_o = pc_plus4;
    endcase
  end

  always_comb begin
    case (opcode_i)
      core_pkg::JAL, core_pkg::JALR: wdata_o = pc_plus4;
      core_pkg::LOAD:                wdata_o = load_q;
      default:                       wdata_o = alu_res;
    endcase
  end

  assign ready_o     = (state_q == IDLE);
  assign retire_o    = (state_q == EXEC);
  assign waddr_o     = rd_i;
  assign wen_o       = retire_o && rwen_i;
  assign halt_o      = halt_q;
  assign mem_req_o   = (state_q == MEM_REQ) || (state_q == MEM_WAIT);
  assign mem_addr_o  = alu_res;
  assign mem_we_o    = (opcode_i == core_pkg::STORE);
  assign mem_wdata_o = op2_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      halt_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (valid_i) begin
            state_q <= is_mem ? MEM_REQ : EXEC;
          end
        end
        EXEC: begin
          state_q <= IDLE;
          if (opcode_i == core_pkg::SYSTEM) begin
            halt_q <= 1'b1;
          end
        end
        default: begin
          if (mem_ack_i) begin
            state_q <= EXEC;
          end else begin
            state_q <= MEM_WAIT;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req_o && mem_ack_i) begin
      load_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     ifu_req_i,
  input  wire mem_pkg::mem_addr_t ifu_addr_i,
  output logic                    ifu_ack_o,
  output mem_pkg::mem_data_t      ifu_rdata_o,
  input  wire                     exu_req_i,
  input  wire mem_pkg::mem_addr_t exu_addr_i,
  input  wire                     exu_we_i,
  input  wire mem_pkg::mem_data_t exu_wdata_i,
  output logic                    exu_ack_o,
  output mem_pkg::mem_data_t      exu_rdata_o,
  output logic                    mem_req_o,
  output mem_pkg::mem_addr_t      mem_addr_o,
  output logic                    mem_we_o,
  output mem_pkg::mem_data_t      mem_wdata_o,
  input  wire                     mem_ack_i,
  input  wire mem_pkg::mem_data_t mem_rdata_i
);

  mem_pkg::requester_e owner_q;
  mem_pkg::requester_e sel;
  logic                busy_q;

  // An idle cycle grants directly and the execute unit wins a tie
  assign sel = busy_q ? owner_q : (exu_req_i ? mem_pkg::REQ_EXU : mem_pkg::REQ_IFU);

  assign mem_req_o   = (sel == mem_pkg::REQ_EXU) ? exu_req_i : ifu_req_i;
  assign mem_addr_o  = (sel == mem_pkg::REQ_EXU) ? exu_addr_i : ifu_addr_i;
  assign mem_we_o    = (sel == mem_pkg::REQ_EXU) && exu_we_i;
  assign mem_wdata_o = (sel == mem_pkg::REQ_EXU) ? exu_wdata_i : '0;

  assign ifu_ack_o   = mem_ack_i && (sel == mem_pkg::REQ_IFU);
  assign exu_ack_o   = mem_ack_i && (sel == mem_pkg::REQ_EXU);
  assign ifu_rdata_o = mem_rdata_i;
  assign exu_rdata_o = mem_rdata_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      owner_q <= mem_pkg::REQ_IFU;
    end else if (mem_ack_i) begin
      busy_q <= 1'b0;
    end else if (!busy_q && mem_req_o) begin
      busy_q  <= 1'b1;
      owner_q <= sel;
    end
  end

  one_ack_a: assert property (@(posedge clk) disable iff (rst)
    !(ifu_ack_o && exu_ack_o));

  // Grant holds from the first request cycle until the ack
  grant_stable_a: assert property (@(posedge clk) disable iff (rst)
    (mem_req_o && !mem_ack_i) |=> $stable(sel));

endmodule

`default_nettype wire

// ==== src/npc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module npc_top #(
  parameter int NUM_REGS = 32
) (
  input  wire                   clk,
  input  wire                   rst,
  output logic                  mem_req_o,
  output mem_pkg::mem_addr_t    mem_addr_o,
  output logic                  mem_we_o,
  output mem_pkg::mem_data_t    mem_wdata_o,
  input  wire mem_pkg::mem_data_t mem_rdata_i,
  input  wire                   mem_ack_i,
  output logic                  halt_o
);

  // Fetch to decode
  logic                if_valid;
  logic                id_ready;
  core_pkg::inst_t     if_inst;
  core_pkg::word_t     if_pc;

  // Decode to execute
  logic                id_valid;
  logic                ex_ready;
  core_pkg::word_t     id_op1;
  core_pkg::word_t     id_op2;
  core_pkg::word_t     id_imm;
  core_pkg::word_t     id_pc;
  core_pkg::reg_addr_t id_rd;
  logic                id_rwen;
  core_pkg::alu_op_e   id_alu_op;
  core_pkg::opcode_e   id_opcode;
  logic                id_is_bne;

  // Register file
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  core_pkg::word_t     rdata1;
  core_pkg::word_t     rdata2;

  // Retire and write back
  logic                exu_valid;
  core_pkg::word_t     next_pc;
  core_pkg::word_t     wb_data;
  core_pkg::reg_addr_t wb_addr;
  logic                wb_en;

  // Peer memory links
  logic                ifu_req;
  mem_pkg::mem_addr_t  ifu_addr;
  logic                ifu_ack;
  mem_pkg::mem_data_t  ifu_rdata;
  logic                exu_req;
  mem_pkg::mem_addr_t  exu_addr;
  logic                exu_we;
  mem_pkg::mem_data_t  exu_wdata;
  logic                exu_ack;
  mem_pkg::mem_data_t  exu_rdata;

  ifu ifu_i (
    .clk         (clk),
    .rst         (rst),
    .retire_i    (exu_valid),
    .next_pc_i   (next_pc),
    .halt_i      (halt_o),
    .ready_i     (id_ready),
    .valid_o     (if_valid),
    .inst_o      (if_inst),
    .pc_o        (if_pc),
    .mem_req_o   (ifu_req),
    .mem_addr_o  (ifu_addr),
    .mem_ack_i   (ifu_ack),
    .mem_rdata_i (ifu_rdata)
  );

  idu idu_i (
    .clk      (clk),
    .rst      (rst),
    .valid_i  (if_valid),
    .ready_o  (id_ready),
    .inst_i   (if_inst),
    .pc_i     (if_pc),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .valid_o  (id_valid),
    .ready_i  (ex_ready),
    .op1_o    (id_op1),
    .op2_o    (id_op2),
    .imm_o    (id_imm),
    .pc_o     (id_pc),
    .rd_o     (id_rd),
    .rwen_o   (id_rwen),
    .alu_op_o (id_alu_op),
    .opcode_o (id_opcode),
    .is_bne_o (id_is_bne)
  );

  exu exu_i (
    .clk         (clk),
    .rst         (rst),
    .valid_i     (id_valid),
    .ready_o     (ex_ready),
    .op1_i       (id_op1),
    .op2_i       (id_op2),
    .imm_i       (id_imm),
    .pc_i        (id_pc),
    .rd_i        (id_rd),
    .rwen_i      (id_rwen),
    .alu_op_i    (id_alu_op),
    .opcode_i    (id_opcode),
    .is_bne_i    (id_is_bne),
    .retire_o    (exu_valid),
    .next_pc_o   (next_pc),
    .wdata_o     (wb_data),
    .waddr_o     (wb_addr),
    .wen_o       (wb_en),
    .halt_o      (halt_o),
    .mem_req_o   (exu_req),
    .mem_addr_o  (exu_addr),
    .mem_we_o    (exu_we),
    .mem_wdata_o (exu_wdata),
    .mem_ack_i   (exu_ack),
    .mem_rdata_i (exu_rdata)
  );

  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) reg_file_i (
    .clk      (clk),
    .rst      (rst),
    .we_i     (wb_en),
    .waddr_i  (wb_addr),
    .wdata_i  (wb_data),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  mem_arbiter mem_arbiter_i (
    .clk         (clk),
    .rst         (rst),
    .ifu_req_i   (ifu_req),
    .ifu_addr_i  (ifu_addr),
    .ifu_ack_o   (ifu_ack),
    .ifu_rdata_o (ifu_rdata),
    .exu_req_i   (exu_req),
    .exu_addr_i  (exu_addr),
    .exu_we_i    (exu_we),
    .exu_wdata_i (exu_wdata),
    .exu_ack_o   (exu_ack),
    .exu_rdata_o (exu_rdata),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_we_o    (mem_we_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

endmodule

`default_nettype wire

// ==== verification/tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_checker #(
  parameter int MAX_STORES = 3
) (
  input wire                     clk,
  input wire                     rst,
  input wire                     mem_req_i,
  input wire                     mem_we_i,
  input wire                     mem_ack_i,
  input wire mem_pkg::mem_addr_t mem_addr_i,
  input wire mem_pkg::mem_data_t mem_wdata_i,
  input wire                     halt_i
);

  string                             name_q = "";
  int                                exp_cnt_q = 0;
  logic [0:MAX_STORES-1][31:0]       exp_addr_q = '0;
  logic [0:MAX_STORES-1][31:0]       exp_data_q = '0;
  int                                stores_seen = 0;
  int                                bad_stores = 0;
  int                                tests_run = 0;
  int                                tests_failed = 0;

  // A store completes on the cycle its ack is seen
  always @(posedge clk) begin
    if (rst) begin
      stores_seen <= 0;
      bad_stores  <= 0;
    end else if (mem_req_i && mem_we_i && mem_ack_i) begin
      stores_seen <= stores_seen + 1;
      if (halt_i) begin
        $display("%s: store of %h to %h after halt", name_q, mem_wdata_i, mem_addr_i);
        bad_stores <= bad_stores + 1;
      end else if (stores_seen >= exp_cnt_q) begin
        $display("%s: unexpected extra store of %h to %h", name_q, mem_wdata_i, mem_addr_i);
        bad_stores <= bad_stores + 1;
      end else if ((mem_addr_i != exp_addr_q[stores_seen]) ||
                   (mem_wdata_i != exp_data_q[stores_seen])) begin
        $display("Mismatch %s store %0d: expected %h at %h, actual %h at %h", name_q,
                 stores_seen, exp_data_q[stores_seen], exp_addr_q[stores_seen],
                 mem_wdata_i, mem_addr_i);
        bad_stores <= bad_stores + 1;
      end
    end
  end

  task automatic start_test(input string name, input int count,
                            input logic [0:MAX_STORES-1][31:0] addrs,
                            input logic [0:MAX_STORES-1][31:0] data);
    name_q     = name;
    exp_cnt_q  = count;
    exp_addr_q = addrs;
    exp_data_q = data;
  endtask

  task automatic finish_test();
    logic ok;
    ok = 1'b1;
    if (!halt_i) begin
      $display("%s: halt_o never rose", name_q);
      ok = 1'b0;
    end
    if (stores_seen < exp_cnt_q) begin
      $display("%s: only %0d of %0d stores were seen", name_q, stores_seen, exp_cnt_q);
      ok = 1'b0;
    end
    if (bad_stores != 0) begin
      ok = 1'b0;
    end
    tests_run++;
    if (ok) begin
      $display("%s: passed with %0d stores", name_q, stores_seen);
    end else begin
      tests_failed++;
      $display("%s: failed", name_q);
    end
  endtask

  task automatic report_counts();
    $display("Tests run: %0d, passed: %0d, failed: %0d", tests_run,
             tests_run - tests_failed, tests_failed);
  endtask

endmodule

`default_nettype wire

// ==== verification/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_top;

  localparam int          CLK_PERIOD  = 8;
  localparam int          NUM_TESTS   = 6;
  localparam int          PROG_WORDS  = 12;
  localparam int          MAX_STORES  = 3;
  localparam int          MEM_WORDS   = 64;
  localparam int          MAX_LATENCY = 3;
  localparam int          HALT_LIMIT  = PROG_WORDS * 8 * MAX_LATENCY;
  localparam int          WATCHDOG_NS = NUM_TESTS * HALT_LIMIT * CLK_PERIOD;
  localparam int          DRAIN       = 16;
  localparam logic [31:0] SEED        = 32'h7581_bff0;
  localparam logic [31:0] EBREAK      = 32'h0010_0073;

  // Programs start at address 0 and data lives from 0x80 upwards
  localparam logic [31:0] PROG [NUM_TESTS][PROG_WORDS] = '{
    // addi x1,7 / addi x2,5 / addi x3,3 / add x4,x1,x2 / sub x5,x4,x3 / sw x5,128(x0)
    '{32'h00700093, 32'h00500113, 32'h00300193, 32'h00208233, 32'h403202b3, 32'h08502023,
      EBREAK, EBREAK, EBREAK, EBREAK, EBREAK, EBREAK},
    // lui x1,0xdeadc / addi x1,x1,-0x111 / addi x2,0x90 / sw x1,8(x2)
    '{32'hdeadc0b7, 32'heef08093, 32'h09000113, 32'h00112423, EBREAK, EBREAK,
      EBREAK, EBREAK, EBREAK, EBREAK, EBREAK, EBREAK},
    // addi x1,0x123 / addi x2,0xa0 / sw x1,0(x2) / lw x3,0(x2) / sw x3,4(x2)
    '{32'h12300093, 32'h0a000113, 32'h00112023, 32'h00012183, 32'h00312223, EBREAK,
      EBREAK, EBREAK, EBREAK, EBREAK, EBREAK, EBREAK},
    // beq taken over sw, bne falls through to sw, bne taken over sw, last sw
    '{32'h00100093, 32'h00100113, 32'h0b000193, 32'h00208463, 32'h0011a023, 32'h00209463,
      32'h0021a223, 32'h00009463, 32'h0011a423, 32'h0031a623, EBREAK, EBREAK},
    // jal x1,+16 to sw x1,4(x3) then jalr x5,1(x1) back to sw x1 and sw x5
    '{32'h0c000193, 32'h010000ef, 32'h0011a023, 32'h0051a423, EBREAK, 32'h0011a223,
      32'h001082e7, EBREAK, EBREAK, EBREAK, EBREAK, EBREAK},
    // addi x0,5 / addi x3,0xd0 / sw x0,0(x3) / ebreak / sw x3,4(x3) never runs
    '{32'h00500013, 32'h0d000193, 32'h0001a023, EBREAK, 32'h0031a223, EBREAK,
      EBREAK, EBREAK, EBREAK, EBREAK, EBREAK, EBREAK}
  };

  localparam int EXP_CNT [NUM_TESTS] = '{1, 1, 2, 2, 3, 1};

  localparam logic [0:MAX_STORES-1][31:0] EXP_ADDR [NUM_TESTS] = '{
    '{32'h80, 32'h0, 32'h0},
    '{32'h90 + 32'd8, 32'h0, 32'h0},
    '{32'ha0, 32'ha0 + 32'd4, 32'h0},
    '{32'hb0 + 32'd4, 32'hb0 + 32'd12, 32'h0},
    '{32'hc0 + 32'd4, 32'hc0, 32'hc0 + 32'd8},
    '{32'hd0, 32'h0, 32'h0}
  };

  // Link values are the jump's own pc plus 4
  localparam logic [0:MAX_STORES-1][31:0] EXP_DATA [NUM_TESTS] = '{
    '{32'd7 + 32'd5 - 32'd3, 32'h0, 32'h0},
    '{32'hdead_beef, 32'h0, 32'h0},
    '{32'h123, 32'h123, 32'h0},
    '{32'd1, 32'hb0, 32'h0},
    '{32'd4 + 32'd4, 32'd4 + 32'd4, 32'd24 + 32'd4},
    '{32'd0, 32'h0, 32'h0}
  };

  string names [NUM_TESTS] = '{"arith", "lui_addi", "load_store", "branches", "jumps",
                               "x0_halt"};

  logic               clk = 1'b0;
  logic               rst = 1'b1;
  logic               mem_req;
  mem_pkg::mem_addr_t mem_addr;
  logic               mem_we;
  mem_pkg::mem_data_t mem_wdata;
  mem_pkg::mem_data_t mem_rdata = '0;
  logic               mem_ack = 1'b0;
  logic               halt;
  mem_pkg::mem_data_t mem [MEM_WORDS];
  logic               pending = 1'b0;
  int unsigned        wait_cnt = 0;
  int                 test_idx = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  npc_top #(
    .NUM_REGS (32)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .mem_req_o   (mem_req),
    .mem_addr_o  (mem_addr),
    .mem_we_o    (mem_we),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata),
    .mem_ack_i   (mem_ack),
    .halt_o      (halt)
  );

  tb_checker #(
    .MAX_STORES (MAX_STORES)
  ) check_i (
    .clk         (clk),
    .rst         (rst),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_ack_i   (mem_ack),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .halt_i      (halt)
  );

  // Memory model that reloads while reset is held
  always @(posedge clk) begin
    if (rst) begin
      mem_ack <= 1'b0;
      pending <= 1'b0;
      for (int i = 0; i < PROG_WORDS; i++) begin
        mem[i] <= PROG[test_idx][i];
      end
      for (int i = PROG_WORDS; i < MEM_WORDS; i++) begin
        mem[i] <= {16'hfeed, 16'(i * 4)};
      end
    end else if (mem_ack) begin
      mem_ack <= 1'b0;
    end else if (mem_req) begin
      if (!pending) begin
        pending  <= 1'b1;
        // Ack lands 1 to 3 cycles after the request is seen
        wait_cnt <= $urandom % MAX_LATENCY;
      end else if (wait_cnt == 0) begin
        pending   <= 1'b0;
        mem_ack   <= 1'b1;
        mem_rdata <= mem[mem_addr[7:2]];
        if (mem_we) begin
          mem[mem_addr[7:2]] <= mem_wdata;
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  task automatic run_test(input int t);
    int cycles;
    test_idx = t;
    check_i.start_test(names[t], EXP_CNT[t], EXP_ADDR[t], EXP_DATA[t]);
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (!halt && (cycles < HALT_LIMIT)) begin
      @(posedge clk);
      cycles++;
    end
    // Extra cycles catch any store after halt
    repeat (DRAIN) @(posedge clk);
    check_i.finish_test();
  endtask

  initial begin
    void'($urandom(SEED));
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    check_i.report_counts();
    if ((check_i.tests_failed == 0) && (check_i.tests_run == NUM_TESTS)) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/core_pkg.sv
src/mem_pkg.sv
src/reg_file.sv
src/ifu.sv
src/idu.sv
src/exu.sv
src/mem_arbiter.sv
src/npc_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TOP        ?= tb_top
RTL_TOP    ?= npc_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_TEXT  ?= STATUS: FAIL
PASS_TEXT  ?= STATUS: PASS
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: lint sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "No result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
